/* hdl/isaPkg.sv */
package isaPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // primary opcodes
    localparam opcode_t opRFormat = 6'h00;
    localparam opcode_t opAddi    = 6'h08;
    localparam opcode_t opAddiu   = 6'h09;
    localparam opcode_t opBeq     = 6'h04;
    localparam opcode_t opBne     = 6'h05;
    localparam opcode_t opLw      = 6'h23;
    localparam opcode_t opSw      = 6'h2b;
    localparam opcode_t opJ       = 6'h02;

    // funct field under R-format
    localparam funct_t functAdd  = 6'h20;
    localparam funct_t functSub  = 6'h22;
    localparam funct_t functAnd  = 6'h24;
    localparam funct_t functMult = 6'h18;
    localparam funct_t functDiv  = 6'h1a;

    typedef enum logic [3:0] {
        aluReg, aluImm, branchEq, branchNe, load,
        store, jump, mult, div, illegal
    } instrClass_t;

    typedef enum logic [2:0] {
        aluPass    = 3'd0,
        aluAdd     = 3'd1,
        aluSub     = 3'd2,
        aluAnd     = 3'd3,
        aluCompare = 3'd7
    } aluOp_t;

    typedef struct packed {
        instrClass_t instrClass;
        aluOp_t      aluOp;
        logic        trapsOverflow; // ADD, SUB, ADDI only
    } decodedInstr_t;

endpackage

/* hdl/ctrlPkg.sv */
package ctrlPkg;

    typedef enum logic [4:0] {
        fetch1, fetch2, fetch3, decode1, decode2, execute,
        aluWriteBack, aluCommit, branchResolve,
        load2, load3, load4,
        store2, store3, store4, store5,
        multWait, multDone, divWait, divDone,
        opcodeCause1, opcodeCause2,
        overflowCause1, overflowCause2,
        divZeroCause1, divZeroCause2,
        vector1, vector2, vector3,
        instrEnd
    } state_t;

    typedef enum logic [2:0] {
        regDstRt = 3'd0,
        regDstRd = 3'd1
    } regDst_t;

    typedef enum logic [3:0] {
        memToRegAluOut = 4'd0,
        memToRegMem    = 4'd1
    } memToReg_t;

    typedef enum logic [2:0] {
        pcSrcMem    = 3'd0, // exception vector read
        pcSrcAlu    = 3'd1,
        pcSrcAluOut = 3'd2, // branch target
        pcSrcJump   = 3'd3
    } pcSource_t;

    typedef enum logic [1:0] {
        aluSrcAPc  = 2'd0,
        aluSrcAReg = 2'd1
    } aluSrcA_t;

    typedef enum logic [1:0] {
        aluSrcBReg      = 2'd0,
        aluSrcBFour     = 2'd1,
        aluSrcBSignExt  = 2'd2,
        aluSrcBShiftImm = 2'd3
    } aluSrcB_t;

    typedef enum logic [2:0] {
        ioRdPc          = 3'd0,
        ioRdAluResult   = 3'd1,
        ioRdAluOut      = 3'd2,
        ioRdOpcodeVec   = 3'd3,
        ioRdOverflowVec = 3'd4,
        ioRdDivZeroVec  = 3'd5
    } ioRd_t;

    typedef struct packed {
        logic overflow;
        logic equal;
        logic multStop;
        logic divStop;
        logic divZero;
    } aluFlags_t;

    typedef struct packed {
        logic           memWrite;
        logic           pcWrite;
        logic           irWrite;
        logic           regWrite;
        logic           abWrite;
        logic           hiloWrite;
        logic           aluOutWrite;
        logic           epcWrite;
        logic           multStart; // one-cycle pulses
        logic           divStart;
        isaPkg::aluOp_t aluOp;
        regDst_t        regDst;
        memToReg_t      memToReg;
        pcSource_t      pcSource;
        aluSrcA_t       aluSrcA;
        aluSrcB_t       aluSrcB;
        logic           hiloSelect; // 0 mult, 1 div
        ioRd_t          ioRd;
    } ctrlWord_t;

endpackage

/* hdl/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
    input  isaPkg::opcode_t       opcode,
    input  isaPkg::funct_t        funct,
    output isaPkg::decodedInstr_t decoded
);
    import isaPkg::*;

    always_comb begin
        decoded.instrClass    = illegal;
        decoded.aluOp         = aluPass;
        decoded.trapsOverflow = 1'b0;
        case (opcode)
            opRFormat: begin
                case (funct)
                    functAdd: begin
                        decoded.instrClass    = aluReg;
                        decoded.aluOp         = aluAdd;
                        decoded.trapsOverflow = 1'b1;
                    end
                    functSub: begin
                        decoded.instrClass    = aluReg;
                        decoded.aluOp         = aluSub;
                        decoded.trapsOverflow = 1'b1;
                    end
                    functAnd: begin
                        decoded.instrClass = aluReg;
                        decoded.aluOp      = aluAnd;
                    end
                    functMult: decoded.instrClass = mult;
                    functDiv:  decoded.instrClass = div;
                    default:   decoded.instrClass = illegal;
                endcase
            end
            opAddi: begin
                decoded.instrClass    = aluImm;
                decoded.aluOp         = aluAdd;
                decoded.trapsOverflow = 1'b1;
            end
            opAddiu: begin
                decoded.instrClass = aluImm; // unsigned add, never traps
                decoded.aluOp      = aluAdd;
            end
            opBeq: begin
                decoded.instrClass = branchEq;
                decoded.aluOp      = aluCompare;
            end
            opBne: begin
                decoded.instrClass = branchNe;
                decoded.aluOp      = aluCompare;
            end
            opLw: begin
                decoded.instrClass = load;
                decoded.aluOp      = aluAdd; // address calc
            end
            opSw: begin
                decoded.instrClass = store;
                decoded.aluOp      = aluAdd;
            end
            opJ:     decoded.instrClass = jump;
            default: decoded.instrClass = illegal;
        endcase
    end

endmodule

/* hdl/cycleSequencer.sv */
`timescale 1ns/10ps

module cycleSequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  isaPkg::decodedInstr_t decoded,
    input  ctrlPkg::aluFlags_t    flags,
    output ctrlPkg::state_t       state
);
    import isaPkg::*;
    import ctrlPkg::*;

    state_t nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch1;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = fetch1;
        case (state)
            // shared fetch and decode
            fetch1:  nextState = fetch2;
            fetch2:  nextState = fetch3;
            fetch3:  nextState = decode1;
            decode1: nextState = decode2;
            decode2: nextState = execute;

            execute: begin
                case (decoded.instrClass)
                    aluReg, aluImm:     nextState = aluWriteBack;
                    branchEq, branchNe: nextState = branchResolve;
                    load:               nextState = load2;
                    store:              nextState = store2;
                    jump:               nextState = instrEnd;
                    mult:               nextState = multWait;
                    div:                nextState = divWait;
                    default:            nextState = opcodeCause1;
                endcase
            end

            aluWriteBack: begin
                if (decoded.trapsOverflow && flags.overflow) begin
                    nextState = overflowCause1;
                end else begin
                    nextState = aluCommit;
                end
            end
            aluCommit:     nextState = fetch1; // end state skipped
            branchResolve: nextState = instrEnd;

            load2: nextState = load3;
            load3: nextState = load4;
            load4: nextState = instrEnd;

            store2: nextState = store3;
            store3: nextState = store4;
            store4: nextState = store5;
            store5: nextState = instrEnd;

            multWait: begin
                if (flags.multStop) begin
                    nextState = multDone;
                end else begin
                    nextState = multWait;
                end
            end
            multDone: nextState = instrEnd;

            divWait: begin
                // zero divisor wins over a stop in the same cycle
                if (flags.divZero) begin
                    nextState = divZeroCause1;
                end else if (flags.divStop) begin
                    nextState = divDone;
                end else begin
                    nextState = divWait;
                end
            end
            divDone: nextState = instrEnd;

            opcodeCause1:   nextState = opcodeCause2;
            opcodeCause2:   nextState = vector1;
            overflowCause1: nextState = overflowCause2;
            overflowCause2: nextState = vector1;
            divZeroCause1:  nextState = divZeroCause2;
            divZeroCause2:  nextState = vector1;

            vector1: nextState = vector2; // vector read wait
            vector2: nextState = vector3;
            vector3: nextState = instrEnd;

            instrEnd: nextState = fetch1;
            default:  nextState = fetch1;
        endcase
    end

endmodule

/* hdl/controlEncoder.sv */
`timescale 1ns/10ps

module controlEncoder (
    input  ctrlPkg::state_t       state,
    input  isaPkg::decodedInstr_t decoded,
    input  logic                  equal,
    output ctrlPkg::ctrlWord_t    ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    // register A against B or the immediate, with the decoded operation
    function automatic ctrlWord_t withOperands(input ctrlWord_t word,
                                               input decodedInstr_t instr);
        ctrlWord_t w;
        w         = word;
        w.aluSrcA = aluSrcAReg;
        w.aluOp   = instr.aluOp;
        if (instr.instrClass == aluImm || instr.instrClass == load ||
            instr.instrClass == store) begin
            w.aluSrcB = aluSrcBSignExt;
        end else begin
            w.aluSrcB = aluSrcBReg;
        end
        return w;
    endfunction

    always_comb begin
        ctrl = '0;
        case (state)
            fetch1, fetch2: begin
                ctrl.aluSrcA = aluSrcAPc; // PC + 4
                ctrl.aluSrcB = aluSrcBFour;
                ctrl.aluOp   = aluAdd;
                if (state == fetch2) begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = pcSrcAlu;
                end
            end
            fetch3: ctrl.irWrite = 1'b1;
            decode1: begin
                // branch target into ALU out
                ctrl.aluSrcA     = aluSrcAPc;
                ctrl.aluSrcB     = aluSrcBShiftImm;
                ctrl.aluOp       = aluAdd;
                ctrl.aluOutWrite = 1'b1;
            end
            decode2: ctrl.abWrite = 1'b1;

            execute: begin
                case (decoded.instrClass)
                    aluReg, aluImm, load, store: begin
                        ctrl             = withOperands(ctrl, decoded);
                        ctrl.aluOutWrite = 1'b1;
                    end
                    branchEq, branchNe: ctrl = withOperands(ctrl, decoded);
                    jump: begin
                        ctrl.pcWrite  = 1'b1;
                        ctrl.pcSource = pcSrcJump;
                    end
                    mult:    ctrl.multStart = 1'b1;
                    div:     ctrl.divStart  = 1'b1;
                    default: ctrl = '0;
                endcase
            end

            // operands held so the overflow flag stays valid
            aluWriteBack: ctrl = withOperands(ctrl, decoded);
            aluCommit: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = memToRegAluOut;
                if (decoded.instrClass == aluReg) begin
                    ctrl.regDst = regDstRd;
                end else begin
                    ctrl.regDst = regDstRt;
                end
            end
            branchResolve: begin
                ctrl          = withOperands(ctrl, decoded);
                ctrl.pcSource = pcSrcAluOut;
                ctrl.pcWrite  = (equal == (decoded.instrClass == branchEq));
            end

            load2, load3, store2, store3, store4: ctrl.ioRd = ioRdAluOut;
            load4: begin
                ctrl.ioRd     = ioRdAluOut;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = memToRegMem;
                ctrl.regDst   = regDstRt;
            end
            store5: begin
                ctrl.ioRd     = ioRdAluOut;
                ctrl.memWrite = 1'b1;
            end

            multDone: begin
                ctrl.hiloWrite  = 1'b1;
                ctrl.hiloSelect = 1'b0;
            end
            divDone: begin
                ctrl.hiloWrite  = 1'b1;
                ctrl.hiloSelect = 1'b1;
            end

            opcodeCause1, overflowCause1, divZeroCause1: begin
                // EPC gets the faulting instruction address
                ctrl.aluSrcA  = aluSrcAPc;
                ctrl.aluSrcB  = aluSrcBFour;
                ctrl.aluOp    = aluSub;
                ctrl.epcWrite = 1'b1;
            end
            opcodeCause2:   ctrl.ioRd = ioRdOpcodeVec;
            overflowCause2: ctrl.ioRd = ioRdOverflowVec;
            divZeroCause2:  ctrl.ioRd = ioRdDivZeroVec;
            vector3: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcSrcMem;
            end

            default: ctrl = '0; // waits and end
        endcase
    end

endmodule

/* hdl/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
    input  logic               clk,
    input  logic               reset,
    input  isaPkg::opcode_t    opcode,
    input  isaPkg::funct_t     funct,
    input  ctrlPkg::aluFlags_t flags,
    output ctrlPkg::ctrlWord_t ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    decodedInstr_t decoded;
    state_t        state;

    instrDecoder decoder (
        .opcode  (opcode),
        .funct   (funct),
        .decoded (decoded)
    );

    cycleSequencer sequencer (
        .clk     (clk),
        .reset   (reset),
        .decoded (decoded),
        .flags   (flags),
        .state   (state)
    );

    // only the compare result matters here
    controlEncoder encoder (
        .state   (state),
        .decoded (decoded),
        .equal   (flags.equal),
        .ctrl    (ctrl)
    );

endmodule

/* tests/controlUnit_chk.sv */
`timescale 1ns/10ps

module controlUnitChk (
    input logic               clk,
    input logic               reset,
    input ctrlPkg::ctrlWord_t ctrl
);

    // one IR load per instruction
    irSingleCycle: assert property (@(posedge clk) disable iff (reset)
        ctrl.irWrite |=> !ctrl.irWrite)
        else $error("irWrite high in two consecutive cycles");

    epcThenVector: assert property (@(posedge clk) disable iff (reset)
        ctrl.epcWrite |-> ##4 ctrl.pcWrite)
        else $error("no vector jump four cycles after epcWrite");

    noMemAndRegWrite: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.memWrite && ctrl.regWrite))
        else $error("memWrite and regWrite high in the same cycle");

endmodule

bind controlUnit controlUnitChk chk (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl)
);

/* tests/controlUnitTb.sv */
`timescale 1ns/10ps

module controlUnitTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int numInstr  = 300;
    localparam int timeoutNs = (numInstr * 40 + 10) * 10;

    logic               clk = 1'b0;
    logic               reset;
    opcode_t            opcode;
    funct_t             funct;
    aluFlags_t          flagsIn;
    ctrlWord_t          ctrl;

    // reference model
    instrClass_t cls;
    aluOp_t      op;
    logic        traps;
    ioRd_t       causeVec;
    int          step;      // cycles since fetch1
    int          endStep;   // -1 while not yet known
    int          trapStep;
    int          doneStep;
    int          instrCount = 0;
    int          trapCount = 0;
    logic        loadNext;

    controlUnit uut (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .flags  (flagsIn),
        .ctrl   (ctrl)
    );

    always #5 clk = ~clk;

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not complete %0d instructions in %0d ns", numInstr,
                 timeoutNs);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic reportMismatch(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic checkField(input logic ok, input string msg);
        assert (ok) else reportMismatch(msg);
    endtask

    function automatic logic [9:0] enables(input ctrlWord_t w);
        return {w.memWrite, w.pcWrite, w.irWrite, w.regWrite, w.abWrite,
                w.hiloWrite, w.aluOutWrite, w.epcWrite, w.multStart, w.divStart};
    endfunction

    task automatic setInstr(input opcode_t o, input funct_t f, input instrClass_t c,
                            input aluOp_t a, input logic t);
        opcode = o;
        funct  = f;
        cls    = c;
        op     = a;
        traps  = t;
    endtask

    task automatic pickInstruction();
        int unsigned kind;
        opcode_t     anyOp;
        funct_t      anyFunct;
        kind     = $urandom % 14;
        anyFunct = 6'($urandom); // ignored outside R-format
        case (kind)
            0:  setInstr(opRFormat, functAdd, aluReg, aluAdd, 1'b1);
            1:  setInstr(opRFormat, functSub, aluReg, aluSub, 1'b1);
            2:  setInstr(opRFormat, functAnd, aluReg, aluAnd, 1'b0);
            3:  setInstr(opRFormat, functMult, mult, aluPass, 1'b0);
            4:  setInstr(opRFormat, functDiv, div, aluPass, 1'b0);
            5:  setInstr(opAddi, anyFunct, aluImm, aluAdd, 1'b1);
            6:  setInstr(opAddiu, anyFunct, aluImm, aluAdd, 1'b0);
            7:  setInstr(opBeq, anyFunct, branchEq, aluCompare, 1'b0);
            8:  setInstr(opBne, anyFunct, branchNe, aluCompare, 1'b0);
            9:  setInstr(opLw, anyFunct, load, aluAdd, 1'b0);
            10: setInstr(opSw, anyFunct, store, aluAdd, 1'b0);
            11: setInstr(opJ, anyFunct, jump, aluPass, 1'b0);
            12: begin
                do begin
                    anyOp = 6'($urandom);
                end while (anyOp inside {opRFormat, opAddi, opAddiu, opBeq, opBne,
                                         opLw, opSw, opJ});
                setInstr(anyOp, anyFunct, illegal, aluPass, 1'b0);
            end
            default: begin
                do begin
                    anyFunct = 6'($urandom);
                end while (anyFunct inside {functAdd, functSub, functAnd, functMult, functDiv});
                setInstr(opRFormat, anyFunct, illegal, aluPass, 1'b0);
            end
        endcase
    endtask

    function automatic aluFlags_t randomFlags();
        aluFlags_t f;
        f.overflow = ($urandom % 4) == 0;
        f.equal    = ($urandom % 2) == 0;
        f.multStop = ($urandom % 6) == 0; // rare, so waits vary
        f.divStop  = ($urandom % 6) == 0;
        f.divZero  = ($urandom % 16) == 0;
        return f;
    endfunction

    // enables the current step should show, with the selects that go with them
    function automatic ctrlWord_t expectedWord();
        ctrlWord_t w;
        w = '0;
        if (trapStep >= 0 && step >= trapStep) begin
            w.epcWrite = (step == trapStep);
            w.pcWrite  = (step == trapStep + 4);
            w.pcSource = pcSrcMem; // vector read from memory
        end else begin
            case (step)
                1: begin
                    w.pcWrite  = 1'b1;
                    w.pcSource = pcSrcAlu;
                end
                2: w.irWrite = 1'b1;
                3: w.aluOutWrite = 1'b1; // branch target
                4: w.abWrite = 1'b1;
                5: begin
                    w.aluOutWrite = (cls inside {aluReg, aluImm, load, store});
                    w.pcWrite     = (cls == jump);
                    w.pcSource    = pcSrcJump;
                    w.multStart   = (cls == mult);
                    w.divStart    = (cls == div);
                end
                default: begin
                    w.regWrite  = ((cls == aluReg || cls == aluImm) && step == 7) ||
                                  (cls == load && step == 8);
                    w.regDst    = (cls == aluReg) ? regDstRd : regDstRt;
                    w.memToReg  = (cls == load) ? memToRegMem : memToRegAluOut;
                    w.pcWrite   = step == 6 && ((cls == branchEq && flagsIn.equal) ||
                                                (cls == branchNe && !flagsIn.equal));
                    w.pcSource  = pcSrcAluOut;
                    w.memWrite  = (cls == store && step == 9);
                    w.hiloWrite = (step == doneStep);
                end
            endcase
        end
        return w;
    endfunction

    task automatic checkCycle();
        ctrlWord_t expWord;
        expWord = expectedWord();
        assert (enables(ctrl) == enables(expWord)) else
            reportMismatch($sformatf("step %0d class %s: enables %b, expected %b",
                                     step, cls.name(), enables(ctrl), enables(expWord)));
        if (trapStep >= 0 && step == trapStep + 1)
            checkField(ctrl.ioRd == causeVec, $sformatf("ioRd %0d, expected cause vector %0d",
                                                        ctrl.ioRd, causeVec));
        if (expWord.pcWrite)
            checkField(ctrl.pcSource == expWord.pcSource,
                       $sformatf("pcSource %0d on PC write, expected %0d", ctrl.pcSource,
                                 expWord.pcSource));
        if (expWord.regWrite)
            checkField(ctrl.regDst == expWord.regDst && ctrl.memToReg == expWord.memToReg,
                       $sformatf("regDst %0d memToReg %0d on register write", ctrl.regDst,
                                 ctrl.memToReg));
        if (trapStep < 0 && step == 5 && (cls == aluReg || cls == aluImm))
            checkField(ctrl.aluOp == op && ctrl.aluSrcA == aluSrcAReg &&
                       ctrl.aluSrcB == ((cls == aluImm) ? aluSrcBSignExt : aluSrcBReg),
                       $sformatf("execute aluOp %0d srcB %0d, expected aluOp %0d",
                                 ctrl.aluOp, ctrl.aluSrcB, op));
        if (step == doneStep)
            checkField(ctrl.hiloSelect == (cls == div), "hiloSelect wrong for unit");
    endtask

    task automatic startTrap(input int at, input ioRd_t vec);
        trapStep = at;
        endStep  = at + 5;
        causeVec = vec;
        trapCount++;
    endtask

    task automatic advanceModel();
        if (step == 5) begin
            case (cls)
                jump:                               endStep = 6;
                aluReg, aluImm, branchEq, branchNe: endStep = 7;
                load:                               endStep = 9;
                store:                              endStep = 10;
                illegal:                            startTrap(6, ioRdOpcodeVec);
                default:                            endStep = -1; // wait for stop flag
            endcase
        end else if (step == 6 && (cls == aluReg || cls == aluImm) && traps &&
                     flagsIn.overflow) begin
            startTrap(7, ioRdOverflowVec);
        end else if (step >= 6 && endStep < 0) begin
            if (cls == div && flagsIn.divZero) begin
                startTrap(step + 1, ioRdDivZeroVec);
            end else if ((cls == mult && flagsIn.multStop) ||
                         (cls == div && flagsIn.divStop)) begin
                doneStep = step + 1;
                endStep  = step + 2;
            end
        end
        if (step == endStep) begin
            step     = 0;
            endStep  = -1;
            trapStep = -1;
            doneStep = -1;
        end else begin
            step++;
        end
    endtask

    initial begin
        void'($urandom(59));
        reset    = 1'b1;
        flagsIn  = '0;
        step     = 0;
        endStep  = -1;
        trapStep = -1;
        doneStep = -1;
        causeVec = ioRdPc;
        pickInstruction();
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        while (instrCount <= numInstr) begin
            @(negedge clk);
            checkCycle();
            loadNext = ctrl.irWrite;
            advanceModel();
            @(posedge clk);
            #1;
            flagsIn = randomFlags();
            if (loadNext) begin
                pickInstruction(); // held until the next irWrite
                instrCount++;
            end
        end
        $display("%0d instructions checked, %0d exceptions", numInstr, trapCount);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* project.f */
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/cycleSequencer.sv
hdl/controlEncoder.sv
hdl/controlUnit.sv
tests/controlUnit_chk.sv
tests/controlUnitTb.sv

/* Makefile */
TOP = controlUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
